/* design/ppu_pkg.sv */
/*
 * PPU blit path shared definitions
 * Field widths, span and pixel mode codes, queue depth
 * and the pixel size lookup used by address gen and unpack
 */

package ppu_pkg;

	// Span command field widths
	localparam int W_COORD_SX = 9;
	localparam int W_COORD_UV = 10;
	localparam int W_ADDR     = 32;
	localparam int W_SPANTYPE = 2;
	localparam int W_PIXMODE  = 2;
	localparam int W_TEXSIZE  = 3;
	localparam int W_DATA     = 16;

	// Span types
	localparam logic [W_SPANTYPE-1:0] SPANTYPE_FILL  = 2'd0;
	localparam logic [W_SPANTYPE-1:0] SPANTYPE_BLIT  = 2'd1;
	localparam logic [W_SPANTYPE-1:0] SPANTYPE_ABLIT = 2'd2;

	// Pixel modes, named by bits per pixel
	localparam logic [W_PIXMODE-1:0] PIXMODE_16 = 2'd0;
	localparam logic [W_PIXMODE-1:0] PIXMODE_8  = 2'd1;
	localparam logic [W_PIXMODE-1:0] PIXMODE_4  = 2'd2;
	localparam logic [W_PIXMODE-1:0] PIXMODE_1  = 2'd3;

	// Bus transfer size code, reads are always halfwords
	localparam logic [1:0] BUS_SIZE_HALF = 2'd1;

	// Metadata queue, discard flag above a 4-bit halfword index
	localparam int PINFO_DEPTH = 4;
	localparam int W_PINFO     = 5;

	// Log2 of bits per pixel
	function automatic logic [2:0] mode_log_pixsize(input logic [W_PIXMODE-1:0] mode);
		case (mode)
			PIXMODE_16: return 3'd4;
			PIXMODE_8:  return 3'd3;
			PIXMODE_4:  return 3'd2;
			PIXMODE_1:  return 3'd0;
			default:    return 3'd4;
		endcase
	endfunction

endpackage

/* design/sync_fifo.sv */
/*
 * Synchronous FIFO
 * Register array with first-word fall-through read port,
 * full and empty flags from an occupancy count
 */

`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] w_data,
	input  logic             w_en,
	output logic [WIDTH-1:0] r_data,
	input  logic             r_en,
	output logic             full,
	output logic             empty
);

	localparam int W_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int W_CNT = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [W_PTR-1:0] wr_ptr;
	logic [W_PTR-1:0] rd_ptr;
	logic [W_CNT-1:0] count;
	logic             wr;
	logic             rd;

	// Ignore pushes when full, pops when empty
	assign wr = w_en && !full;
	assign rd = r_en && !empty;

	// Storage
	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= w_data;
	end

	// Pointers wrap at DEPTH, any depth allowed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr && !rd)
				count <= count + 1'b1;
			else if (rd && !wr)
				count <= count - 1'b1;
		end
	end

	// Head entry shows without a pop
	assign r_data = mem[rd_ptr];
	assign full   = count == W_CNT'(DEPTH);
	assign empty  = count == '0;

endmodule

/* design/ppu_coord_gen.sv */
/*
 * PPU coordinate generator
 * Loads the span start point, then steps u by one per
 * accepted coordinate; v stays fixed across the span
 */

`timescale 1ns/1ps

module ppu_coord_gen
	import ppu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  span_start,
	input  logic [W_COORD_UV-1:0] span_u,
	input  logic [W_COORD_UV-1:0] span_v,

	output logic [W_COORD_UV-1:0] cgen_u,
	output logic [W_COORD_UV-1:0] cgen_v,
	output logic                  cgen_vld,
	input  logic                  cgen_rdy
);

	logic step;

	// Handshake with the address unit
	assign step = cgen_vld && cgen_rdy;

	// ------------------------------------------------------------
	// Valid flag
	// ------------------------------------------------------------

	// Stream never ends by itself
	// AGU decides when the span is over
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cgen_vld <= 1'b0;
		else if (span_start)
			cgen_vld <= 1'b1;
	end

	// ------------------------------------------------------------
	// Coordinates
	// ------------------------------------------------------------

	// Start point lands the cycle after span_start
	// Unaffine stepping, u only
	always_ff @(posedge clk) begin
		if (span_start) begin
			cgen_u <= span_u;
			cgen_v <= span_v;
		end else if (step) begin
			cgen_u <= cgen_u + 1'b1;
		end
	end

endmodule

/* design/ppu_pixel_agu.sv */
/*
 * PPU pixel address unit
 * Counts span pixels, bounds-checks each coordinate, issues
 * halfword bus reads and queues per-pixel metadata for unpack
 */

`timescale 1ns/1ps

module ppu_pixel_agu
	import ppu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	// Span command
	input  logic                  span_start,
	input  logic [W_COORD_SX-1:0] span_count,
	input  logic [W_SPANTYPE-1:0] span_type,
	input  logic [W_PIXMODE-1:0]  span_pixmode,
	input  logic [W_ADDR-1:0]     span_texture_ptr,
	input  logic [W_TEXSIZE-1:0]  span_texsize,
	input  logic                  span_ablit_halfsize,
	output logic                  span_done,

	// Coordinate stream
	input  logic [W_COORD_UV-1:0] cgen_u,
	input  logic [W_COORD_UV-1:0] cgen_v,
	input  logic                  cgen_vld,
	output logic                  cgen_rdy,

	// Bus address phase
	output logic                  bus_addr_vld,
	input  logic                  bus_addr_rdy,
	output logic [1:0]            bus_size,
	output logic [W_ADDR-1:0]     bus_addr,

	// Metadata to the unpacker
	output logic [3:0]            pinfo_index,
	output logic                  pinfo_discard,
	output logic                  pinfo_vld,
	input  logic                  pinfo_rdy
);

	logic [W_COORD_SX-1:0] count;
	logic [W_SPANTYPE-1:0] stype;
	logic [W_PIXMODE-1:0]  pixmode;
	logic [W_ADDR-1:0]     texture_ptr;
	logic [W_TEXSIZE-1:0]  texsize;

	logic                  blit_mode;
	logic [2:0]            log_bpp;
	logic [W_COORD_UV-1:0] ordinate_mask;
	logic                  out_of_bounds;
	logic [W_ADDR-1:0]     pix_offs;
	logic [W_ADDR-1:0]     bit_offs;
	logic [W_ADDR-1:0]     addr_sum;
	logic                  issue_pixel;
	logic                  pinfo_wen;
	logic                  pinfo_full;
	logic                  pinfo_empty;
	logic [W_PINFO-1:0]    pinfo_wdata;

	// ------------------------------------------------------------
	// Span state
	// ------------------------------------------------------------

	// FILL spans never leave done
	// Count holds pixels left minus one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			span_done <= 1'b1;
			count     <= '0;
			stype     <= SPANTYPE_FILL;
		end else if (span_start) begin
			span_done <= span_type == SPANTYPE_FILL;
			count     <= span_count;
			stype     <= span_type;
		end else if (issue_pixel) begin
			count <= count - 1'b1;
			if (count == '0)
				span_done <= 1'b1;
		end
	end

	// Half-size ABLIT texture is one size step down
	always_ff @(posedge clk) begin
		if (span_start) begin
			pixmode     <= span_pixmode;
			texture_ptr <= span_texture_ptr;
			texsize     <= span_texsize -
				W_TEXSIZE'(span_ablit_halfsize && span_type == SPANTYPE_ABLIT);
		end
	end

	// ------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------

	assign blit_mode = stype == SPANTYPE_BLIT || stype == SPANTYPE_ABLIT;
	assign log_bpp   = mode_log_pixsize(pixmode);

	// Texture is (8 << texsize) pixels square
	// Mask keeps the in-range ordinate bits
	assign ordinate_mask = ~({{(W_COORD_UV - 3){1'b1}}, 3'b000} << texsize);
	assign out_of_bounds = |{cgen_u & ~ordinate_mask, cgen_v & ~ordinate_mask};

	// Row-major pixel offset
	assign pix_offs = W_ADDR'(cgen_u & ordinate_mask) +
		((W_ADDR'(cgen_v & ordinate_mask) << 3) << texsize);

	// Bit offset, then bytes
	assign bit_offs = pix_offs << log_bpp;
	assign addr_sum = texture_ptr + (bit_offs >> 3);

	// Halfword aligned, halfword sized
	assign bus_addr = {addr_sum[W_ADDR-1:1], 1'b0};
	assign bus_size = BUS_SIZE_HALF;

	// Request only for live in-bounds pixels with queue room
	assign bus_addr_vld = blit_mode && !span_done && cgen_vld &&
		!pinfo_full && !out_of_bounds;

	// Out-of-bounds pixels retire without a bus read
	assign issue_pixel = blit_mode && !span_done && cgen_vld && !pinfo_full &&
		(out_of_bounds || bus_addr_rdy);
	assign cgen_rdy = issue_pixel;

	// ------------------------------------------------------------
	// Metadata queue
	// ------------------------------------------------------------

	// Pixel slot inside the halfword
	assign pinfo_wdata = {out_of_bounds, bit_offs[3:0] >> log_bpp};
	assign pinfo_wen   = issue_pixel;

	sync_fifo #(
		.DEPTH (PINFO_DEPTH),
		.WIDTH (W_PINFO)
	) pinfo_fifo_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.w_data (pinfo_wdata),
		.w_en   (pinfo_wen),
		.r_data ({pinfo_discard, pinfo_index}),
		.r_en   (pinfo_vld && pinfo_rdy),
		.full   (pinfo_full),
		.empty  (pinfo_empty)
	);

	assign pinfo_vld = !pinfo_empty;

endmodule

/* design/ppu_pixel_unpack.sv */
/*
 * PPU pixel unpacker
 * Pairs queued metadata with returned bus halfwords and
 * extracts one pixel per cycle at its bit position
 */

`timescale 1ns/1ps

module ppu_pixel_unpack
	import ppu_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 span_start,
	input  logic [W_PIXMODE-1:0] span_pixmode,

	// Bus read data, one strobe per read in address order
	input  logic [W_DATA-1:0]    bus_rdata,
	input  logic                 bus_rdata_vld,

	// Metadata from the address unit
	input  logic [3:0]           pinfo_index,
	input  logic                 pinfo_discard,
	input  logic                 pinfo_vld,
	output logic                 pinfo_rdy,

	// Pixel output strobe
	output logic                 pix_vld,
	output logic [W_DATA-1:0]    pix_data,
	output logic                 pix_discard
);

	logic [W_PIXMODE-1:0] pixmode;
	logic [2:0]           log_bpp;
	logic [4:0]           bpp;
	logic [3:0]           shamt;
	logic [W_DATA:0]      field_mask;
	logic [W_DATA-1:0]    data_head;
	logic                 data_empty;
	logic                 data_pop;

	// Own copy of the mode
	always_ff @(posedge clk) begin
		if (span_start)
			pixmode <= span_pixmode;
	end

	// ------------------------------------------------------------
	// Read data buffer
	// ------------------------------------------------------------

	// Never overflows, reads in flight are bounded by metadata depth
	sync_fifo #(
		.DEPTH (PINFO_DEPTH),
		.WIDTH (W_DATA)
	) data_fifo_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.w_data (bus_rdata),
		.w_en   (bus_rdata_vld),
		.r_data (data_head),
		.r_en   (data_pop),
		.full   (),
		.empty  (data_empty)
	);

	// ------------------------------------------------------------
	// Pairing and extraction
	// ------------------------------------------------------------

	// Discards go at once, others wait for their data
	assign pinfo_rdy = pinfo_vld && (pinfo_discard || !data_empty);
	assign data_pop  = pinfo_vld && !pinfo_discard && !data_empty;

	assign log_bpp = mode_log_pixsize(pixmode);
	assign bpp     = 5'd1 << log_bpp;

	// Index times bpp stays below 16
	assign shamt = pinfo_index << log_bpp;

	// One extra bit so 16 bpp gives all ones
	assign field_mask = (17'd1 << bpp) - 17'd1;

	assign pix_vld     = pinfo_rdy;
	assign pix_discard = pinfo_vld && pinfo_discard;
	assign pix_data    = pinfo_discard ? '0 :
		(data_head >> shamt) & field_mask[W_DATA-1:0];

endmodule

/* design/ppu_blit_top.sv */
/*
 * PPU blit pixel fetch path
 * Coordinate generator, address unit and unpacker in a row
 */

`timescale 1ns/1ps

module ppu_blit_top
	import ppu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	// Span command
	input  logic                  span_start,
	input  logic [W_COORD_SX-1:0] span_count,
	input  logic [W_SPANTYPE-1:0] span_type,
	input  logic [W_PIXMODE-1:0]  span_pixmode,
	input  logic [W_ADDR-1:0]     span_texture_ptr,
	input  logic [W_TEXSIZE-1:0]  span_texsize,
	input  logic                  span_ablit_halfsize,
	input  logic [W_COORD_UV-1:0] span_u,
	input  logic [W_COORD_UV-1:0] span_v,
	output logic                  span_done,

	// Bus address phase
	output logic                  bus_addr_vld,
	input  logic                  bus_addr_rdy,
	output logic [1:0]            bus_size,
	output logic [W_ADDR-1:0]     bus_addr,

	// Bus data phase
	input  logic [W_DATA-1:0]     bus_rdata,
	input  logic                  bus_rdata_vld,

	// Pixels
	output logic                  pix_vld,
	output logic [W_DATA-1:0]     pix_data,
	output logic                  pix_discard
);

	logic [W_COORD_UV-1:0] cgen_u;
	logic [W_COORD_UV-1:0] cgen_v;
	logic                  cgen_vld;
	logic                  cgen_rdy;

	logic [3:0]            pinfo_index;
	logic                  pinfo_discard;
	logic                  pinfo_vld;
	logic                  pinfo_rdy;

	// ------------------------------------------------------------
	// Coordinates
	// ------------------------------------------------------------

	ppu_coord_gen ppu_coord_gen_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.span_start (span_start),
		.span_u     (span_u),
		.span_v     (span_v),
		.cgen_u     (cgen_u),
		.cgen_v     (cgen_v),
		.cgen_vld   (cgen_vld),
		.cgen_rdy   (cgen_rdy)
	);

	// ------------------------------------------------------------
	// Address phase
	// ------------------------------------------------------------

	ppu_pixel_agu ppu_pixel_agu_inst (
		.clk                 (clk),
		.rst_n               (rst_n),
		.span_start          (span_start),
		.span_count          (span_count),
		.span_type           (span_type),
		.span_pixmode        (span_pixmode),
		.span_texture_ptr    (span_texture_ptr),
		.span_texsize        (span_texsize),
		.span_ablit_halfsize (span_ablit_halfsize),
		.span_done           (span_done),
		.cgen_u              (cgen_u),
		.cgen_v              (cgen_v),
		.cgen_vld            (cgen_vld),
		.cgen_rdy            (cgen_rdy),
		.bus_addr_vld        (bus_addr_vld),
		.bus_addr_rdy        (bus_addr_rdy),
		.bus_size            (bus_size),
		.bus_addr            (bus_addr),
		.pinfo_index         (pinfo_index),
		.pinfo_discard       (pinfo_discard),
		.pinfo_vld           (pinfo_vld),
		.pinfo_rdy           (pinfo_rdy)
	);

	// ------------------------------------------------------------
	// Data phase
	// ------------------------------------------------------------

	ppu_pixel_unpack ppu_pixel_unpack_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.span_start    (span_start),
		.span_pixmode  (span_pixmode),
		.bus_rdata     (bus_rdata),
		.bus_rdata_vld (bus_rdata_vld),
		.pinfo_index   (pinfo_index),
		.pinfo_discard (pinfo_discard),
		.pinfo_vld     (pinfo_vld),
		.pinfo_rdy     (pinfo_rdy),
		.pix_vld       (pix_vld),
		.pix_data      (pix_data),
		.pix_discard   (pix_discard)
	);

endmodule

/* tb/ppu_blit_props.sv */
/*
 * PPU address unit properties
 * Bus address alignment and hold, no requests while idle,
 * no metadata push into a full queue
 */

`timescale 1ns/1ps

module ppu_blit_props
	import ppu_pkg::*;
(
	input logic              clk,
	input logic              rst_n,
	input logic              bus_addr_vld,
	input logic              bus_addr_rdy,
	input logic [W_ADDR-1:0] bus_addr,
	input logic              span_done,
	input logic              pinfo_wen,
	input logic              pinfo_full
);

	// Failure count, read by the testbench at the end
	int violations = 0;

	// Reads are always halfword aligned
	assert property (@(posedge clk) disable iff (!rst_n)
		bus_addr_vld |-> !bus_addr[0])
	else begin
		violations++;
		$error("bus address not halfword aligned");
	end

	// Stalled request keeps its address
	assert property (@(posedge clk) disable iff (!rst_n)
		bus_addr_vld && !bus_addr_rdy |=> bus_addr_vld && $stable(bus_addr))
	else begin
		violations++;
		$error("bus address request dropped or changed while stalled");
	end

	// Idle unit stays off the bus
	assert property (@(posedge clk) disable iff (!rst_n)
		!(bus_addr_vld && span_done))
	else begin
		violations++;
		$error("bus address request while span is done");
	end

	// Metadata queue never overrun
	assert property (@(posedge clk) disable iff (!rst_n)
		!(pinfo_wen && pinfo_full))
	else begin
		violations++;
		$error("metadata written while queue full");
	end

endmodule

bind ppu_pixel_agu ppu_blit_props ppu_blit_props_inst (
	.clk          (clk),
	.rst_n        (rst_n),
	.bus_addr_vld (bus_addr_vld),
	.bus_addr_rdy (bus_addr_rdy),
	.bus_addr     (bus_addr),
	.span_done    (span_done),
	.pinfo_wen    (pinfo_wen),
	.pinfo_full   (pinfo_full)
);

/* tb/tb_ppu_blit.sv */
/*
 * PPU blit path testbench
 * Table of spans, bus memory model with two-cycle latency,
 * random address stalls and an in-order pixel reference model
 */

`timescale 1ns/1ps

module tb_ppu_blit
	import ppu_pkg::*;
();

	localparam int N_ROWS = 11;

	logic                  clk;
	logic                  rst_n;
	logic                  span_start;
	logic [W_COORD_SX-1:0] span_count;
	logic [W_SPANTYPE-1:0] span_type;
	logic [W_PIXMODE-1:0]  span_pixmode;
	logic [W_ADDR-1:0]     span_texture_ptr;
	logic [W_TEXSIZE-1:0]  span_texsize;
	logic                  span_ablit_halfsize;
	logic [W_COORD_UV-1:0] span_u;
	logic [W_COORD_UV-1:0] span_v;
	logic                  span_done;
	logic                  bus_addr_vld;
	logic                  bus_addr_rdy;
	logic [1:0]            bus_size;
	logic [W_ADDR-1:0]     bus_addr;
	logic [W_DATA-1:0]     bus_rdata;
	logic                  bus_rdata_vld;
	logic                  pix_vld;
	logic [W_DATA-1:0]     pix_data;
	logic                  pix_discard;

	// Span table
	string                 row_name    [N_ROWS];
	logic [W_SPANTYPE-1:0] row_type    [N_ROWS];
	logic [W_PIXMODE-1:0]  row_mode    [N_ROWS];
	logic [W_TEXSIZE-1:0]  row_texsize [N_ROWS];
	logic                  row_half    [N_ROWS];
	logic [W_COORD_UV-1:0] row_u0      [N_ROWS];
	logic [W_COORD_UV-1:0] row_v0      [N_ROWS];
	logic [W_COORD_SX-1:0] row_count   [N_ROWS];
	logic [W_ADDR-1:0]     row_ptr     [N_ROWS];

	// Expected traffic, discard flag above pixel data
	logic [16:0]           exp_pix  [$];
	logic [W_ADDR-1:0]     exp_addr [$];
	int unsigned           addr_total;
	int unsigned           cycle_count;
	int unsigned           timeout_cycles;
	string                 test_name;

	ppu_blit_top ppu_blit_top_inst (.*);

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Bus memory contents, a function of the whole address
	function automatic logic [15:0] mem_word(input logic [31:0] addr);
		return (addr[15:0] ^ addr[31:16]) + 16'h5a3c;
	endfunction

	function automatic int unsigned bits_per_pixel(input logic [W_PIXMODE-1:0] mode);
		case (mode)
			PIXMODE_8: return 8;
			PIXMODE_4: return 4;
			PIXMODE_1: return 1;
			default:   return 16;
		endcase
	endfunction

	task automatic set_row(input int r, input string name, input logic [1:0] stype,
		input logic [1:0] mode, input logic [2:0] ts, input logic half,
		input logic [9:0] u0, input logic [9:0] v0, input logic [8:0] count,
		input logic [31:0] ptr);
		row_name[r]    = name;
		row_type[r]    = stype;
		row_mode[r]    = mode;
		row_texsize[r] = ts;
		row_half[r]    = half;
		row_u0[r]      = u0;
		row_v0[r]      = v0;
		row_count[r]   = count;
		row_ptr[r]     = ptr;
	endtask

	// Count is pixels minus one
	task automatic load_table();
		set_row(0, "blit16_in", SPANTYPE_BLIT, PIXMODE_16, 3'd1, 1'b0, 10'd2, 10'd3, 9'd9,
			32'h0001_2000);
		set_row(1, "blit8_in", SPANTYPE_BLIT, PIXMODE_8, 3'd0, 1'b0, 10'd1, 10'd5, 9'd6,
			32'h0002_0400);
		set_row(2, "blit4_in", SPANTYPE_BLIT, PIXMODE_4, 3'd2, 1'b0, 10'd5, 10'd9, 9'd12,
			32'h0003_1000);
		// Rows 2 and 3 of an 8-wide 1 bpp texture share one halfword
		set_row(3, "blit1_even_row", SPANTYPE_BLIT, PIXMODE_1, 3'd0, 1'b0, 10'd0, 10'd2,
			9'd9, 32'h0004_0800);
		set_row(4, "blit1_odd_row", SPANTYPE_BLIT, PIXMODE_1, 3'd0, 1'b0, 10'd0, 10'd3,
			9'd7, 32'h0004_0800);
		set_row(5, "blit16_u_oob", SPANTYPE_BLIT, PIXMODE_16, 3'd0, 1'b0, 10'd4, 10'd1,
			9'd7, 32'h0005_0000);
		set_row(6, "blit8_v_oob", SPANTYPE_BLIT, PIXMODE_8, 3'd0, 1'b0, 10'd0, 10'd9, 9'd3,
			32'h0006_0000);
		set_row(7, "fill", SPANTYPE_FILL, PIXMODE_16, 3'd1, 1'b0, 10'd0, 10'd0, 9'd5,
			32'h0007_0000);
		set_row(8, "ablit_half", SPANTYPE_ABLIT, PIXMODE_16, 3'd2, 1'b1, 10'd10, 10'd4,
			9'd9, 32'h0008_2000);
		set_row(9, "ablit_full", SPANTYPE_ABLIT, PIXMODE_8, 3'd1, 1'b0, 10'd12, 10'd15,
			9'd5, 32'h0009_0100);
		set_row(10, "blit4_long", SPANTYPE_BLIT, PIXMODE_4, 3'd3, 1'b0, 10'd0, 10'd63,
			9'd40, 32'h00ab_c000);
	endtask

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	task automatic predict_span(input int r, output int unsigned n_addr);
		int unsigned ts;
		int unsigned width;
		int unsigned bpp;
		int unsigned u;
		int unsigned v;
		int unsigned bit_off;
		int          i;
		logic [31:0] addr;
		logic [31:0] field;
		n_addr = 0;
		if (row_type[r] == SPANTYPE_FILL)
			return;
		// Half-size ABLIT drops one size step
		ts = row_texsize[r];
		if (row_type[r] == SPANTYPE_ABLIT && row_half[r])
			ts = ts - 1;
		width = 8 << ts;
		bpp   = bits_per_pixel(row_mode[r]);
		v     = row_v0[r];
		for (i = 0; i <= row_count[r]; i++) begin
			u = row_u0[r] + i;
			if (u >= width || v >= width) begin
				exp_pix.push_back({1'b1, 16'h0000});
			end else begin
				bit_off = (u + v * width) * bpp;
				addr    = (row_ptr[r] + bit_off / 8) & ~32'd1;
				field   = (32'(mem_word(addr)) >> (bit_off % 16)) & ((32'd1 << bpp) - 1);
				exp_addr.push_back(addr);
				exp_pix.push_back({1'b0, field[15:0]});
				n_addr++;
			end
		end
	endtask

	// ------------------------------------------------------------
	// Clock, bus models, monitor, timeout
	// ------------------------------------------------------------

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Random stalls on the address phase
	initial begin : rdy_driver
		logic [31:0] rnd;
		rnd          = 32'h80d3;
		bus_addr_rdy = 1'b0;
		forever begin
			@(negedge clk);
			rnd          = next_random(rnd);
			bus_addr_rdy = rnd[1:0] != 2'b00;
		end
	end

	// Data returns two cycles after the address is taken
	initial begin : mem_model
		logic        acc_vld;
		logic [31:0] acc_addr;
		logic        d1_vld;
		logic [31:0] d1_addr;
		bus_rdata_vld = 1'b0;
		bus_rdata     = '0;
		d1_vld        = 1'b0;
		d1_addr       = '0;
		forever begin
			@(posedge clk);
			acc_vld  = rst_n && bus_addr_vld && bus_addr_rdy;
			acc_addr = bus_addr;
			@(negedge clk);
			bus_rdata_vld = d1_vld;
			bus_rdata     = d1_vld ? mem_word(d1_addr) : 16'h0000;
			d1_vld        = acc_vld;
			d1_addr       = acc_addr;
		end
	end

	// Addresses and pixels checked in order as they transfer
	always @(posedge clk) begin : monitor
		logic [16:0] e;
		logic [31:0] a;
		if (rst_n && bus_addr_vld && bus_addr_rdy) begin
			addr_total++;
			if (exp_addr.size() == 0) begin
				$display("Bus address %h issued with none expected in %s", bus_addr, test_name);
				abort_run();
			end
			a = exp_addr.pop_front();
			check_value("bus_addr", a, bus_addr);
			check_value("bus_size", 32'(BUS_SIZE_HALF), bus_size);
		end
		if (rst_n && pix_vld) begin
			if (exp_pix.size() == 0) begin
				$display("Pixel output with none expected in %s", test_name);
				abort_run();
			end
			e = exp_pix.pop_front();
			check_value("pix_discard", e[16], pix_discard);
			check_value("pix_data", e[15:0], pix_data);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (timeout_cycles != 0 && cycle_count > timeout_cycles) begin
			$display("Timeout after %0d cycles in %s, the DUT stopped making progress",
				cycle_count, test_name);
			abort_run();
		end
	end

	// ------------------------------------------------------------
	// Span sequencing
	// ------------------------------------------------------------

	task automatic wait_span_done();
		while (!span_done)
			@(negedge clk);
	endtask

	task automatic run_span(input int r);
		int unsigned n_addr;
		int unsigned addr_start;
		test_name = row_name[r];
		wait_span_done();
		predict_span(r, n_addr);
		addr_start = addr_total;
		@(negedge clk);
		span_start          = 1'b1;
		span_count          = row_count[r];
		span_type           = row_type[r];
		span_pixmode        = row_mode[r];
		span_texture_ptr    = row_ptr[r];
		span_texsize        = row_texsize[r];
		span_ablit_halfsize = row_half[r];
		span_u              = row_u0[r];
		span_v              = row_v0[r];
		@(negedge clk);
		span_start = 1'b0;
		check_value("span_done after start", row_type[r] == SPANTYPE_FILL, span_done);
		// FILL must stay idle
		if (row_type[r] == SPANTYPE_FILL) begin
			repeat (8) begin
				@(negedge clk);
				check_value("span_done held", 1, span_done);
			end
		end else begin
			wait_span_done();
		end
		// Drain pixels still in flight
		while (exp_pix.size() != 0)
			@(negedge clk);
		check_value("address count", n_addr, addr_total - addr_start);
	endtask

	initial begin : main
		int r;
		int unsigned total_pixels;
		rst_n               = 1'b0;
		span_start          = 1'b0;
		span_count          = '0;
		span_type           = SPANTYPE_FILL;
		span_pixmode        = PIXMODE_16;
		span_texture_ptr    = '0;
		span_texsize        = '0;
		span_ablit_halfsize = 1'b0;
		span_u              = '0;
		span_v              = '0;
		test_name           = "reset";
		load_table();
		total_pixels = 0;
		for (r = 0; r < N_ROWS; r++)
			total_pixels += row_count[r] + 1;
		timeout_cycles = 20 * total_pixels + 200;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		// Idle state out of reset
		check_value("span_done", 1, span_done);
		check_value("bus_addr_vld", 0, bus_addr_vld);
		check_value("pix_vld", 0, pix_vld);
		for (r = 0; r < N_ROWS; r++)
			run_span(r);
		if (ppu_blit_top_inst.ppu_pixel_agu_inst.ppu_blit_props_inst.violations != 0) begin
			$display("Address unit properties failed during the run");
			abort_run();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

/* sim.f */
design/ppu_pkg.sv
design/sync_fifo.sv
design/ppu_coord_gen.sv
design/ppu_pixel_agu.sv
design/ppu_pixel_unpack.sv
design/ppu_blit_top.sv
tb/ppu_blit_props.sv
tb/tb_ppu_blit.sv
